//--- src/lanePkg.sv
// Lane datapath definitions
// Data word, register index and register file sizing shared by the lane

`default_nettype none

package lanePkg;

	////////////////////
	// Sizing
	////////////////////

	localparam int NUM_REGS  = 32;               // Register file depth
	localparam int NUM_PORTS = 4;                // Register file read ports
	localparam int NUM_SRCS  = 3;                // ALU operands per instruction

	localparam int DATA_W    = 32;               // Lane word width
	localparam int INDEX_W   = $clog2(NUM_REGS); // 5 bits for 32 entries

	////////////////////
	// Datapath types
	////////////////////

	typedef logic [DATA_W-1:0]  data_t;          // One lane data word, unsigned
	typedef logic [INDEX_W-1:0] index_t;         // Register file index

endpackage

`default_nettype wire

//--- src/opPkg.sv
// Lane operation definitions
// ALU opcode encoding and the path-select word with its two readings

`default_nettype none

package opPkg;

	////////////////////
	// ALU opcodes
	////////////////////

	typedef enum logic [2:0] {
		OP_ADD = 3'h0,  // a + b
		OP_SUB = 3'h1,  // a - b
		OP_MAD = 3'h2,  // Low word of a * b + c
		OP_AND = 3'h3,  // a & b
		OP_XOR = 3'h4,  // a ^ b
		OP_SEL = 3'h5   // c != 0 ? a : b
	} aluOp_t;

	////////////////////
	// Path select
	////////////////////

	// Operand view, one read-port pick per ALU source
	typedef struct packed {
		logic [1:0] src3Path;   // Port for operand 3
		logic [1:0] src2Path;   // Port for operand 2
		logic [1:0] src1Path;   // Port for operand 1
	} srcPaths_t;

	// Side-path view, only the low field matters
	typedef struct packed {
		logic [3:0] unused;     // Ignored by the PAC path
		logic [1:0] pacPath;    // Port sent out on the side path
	} pacPaths_t;

	// Same 6-bit word, decoded both ways by the operand network
	typedef union packed {
		srcPaths_t src;
		pacPaths_t pac;
	} pathSel_t;

endpackage

`default_nettype wire

//--- src/laneRegFile.sv
// Lane register file
// 32 words, four combinational read ports and one clocked write port

`timescale 1ns/1ns
`default_nettype none

module laneRegFile
	import lanePkg::*;
(
	input  logic   clock,
	input  logic   rstN,
	input  logic   wrEn,      // Write strobe
	input  index_t wrIdx,     // Write address
	input  data_t  wrData,    // Write word
	input  index_t readIdx1,
	input  index_t readIdx2,
	input  index_t readIdx3,
	input  index_t readIdx4,
	output data_t  rdData1,
	output data_t  rdData2,
	output data_t  rdData3,
	output data_t  rdData4
);

	data_t regs [NUM_REGS];      // Storage array

	////////////////////
	// Write port
	////////////////////

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;          // All registers start at zero
			end
		end else if (wrEn) begin
			regs[wrIdx] <= wrData;
		end
	end

	////////////////////
	// Read ports
	////////////////////

	// No read-during-write forwarding here, the network bypass covers it
	assign rdData1 = regs[readIdx1];
	assign rdData2 = regs[readIdx2];
	assign rdData3 = regs[readIdx3];
	assign rdData4 = regs[readIdx4];

endmodule

`default_nettype wire

//--- src/laneAlu.sv
// Lane ALU
// Three-operand ALU with a registered result that returns as the write-back
// Also registers the side-path word under the same issue

`timescale 1ns/1ns
`default_nettype none

module laneAlu
	import lanePkg::*, opPkg::*;
(
	input  logic   clock,
	input  logic   rstN,
	input  logic   issue,      // Instruction valid this cycle
	input  aluOp_t op,
	input  index_t dstIdx,     // Destination register
	input  data_t  srcData1,   // Operand a
	input  data_t  srcData2,   // Operand b
	input  data_t  srcData3,   // Operand c
	input  data_t  pacIn,      // Side-path word from the network
	output logic   wbValid,
	output index_t wbIdx,
	output data_t  wbData,
	output logic   pacValid,
	output data_t  pacData
);

	data_t aluResult;           // Combinational result

	////////////////////
	// Operation
	////////////////////

	always_comb begin
		case (op)
			OP_ADD: aluResult = srcData1 + srcData2;
			OP_SUB: aluResult = srcData1 - srcData2;
			OP_MAD: aluResult = srcData1 * srcData2 + srcData3;   // Truncated to 32 bits
			OP_AND: aluResult = srcData1 & srcData2;
			OP_XOR: aluResult = srcData1 ^ srcData2;
			OP_SEL: aluResult = (srcData3 != '0) ? srcData1 : srcData2;
			default: aluResult = '0;                              // Unused encodings
		endcase
	end

	////////////////////
	// Output stage
	////////////////////

	// Valid flags follow issue by exactly one cycle
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			wbValid  <= 1'b0;
			pacValid <= 1'b0;
		end else begin
			wbValid  <= issue;
			pacValid <= issue;
		end
	end

	always_ff @(posedge clock) begin
		if (issue) begin
			wbIdx   <= dstIdx;
			wbData  <= aluResult;
			pacData <= pacIn;        // Side word rides with the result
		end
	end

endmodule

`default_nettype wire

//--- src/operandNetwork.sv
// Lane operand network
// Picks up to three ALU operands from the four read ports, with write-back bypass
// Also steers one read port onto the PAC side path

`timescale 1ns/1ns
`default_nettype none

module operandNetwork
	import lanePkg::*, opPkg::*;
(
	input  logic                issue,
	input  logic [NUM_SRCS-1:0] srcEn,      // Bit 0 for operand 1
	input  pathSel_t            pathSel,
	input  index_t              readIdx1,
	input  index_t              readIdx2,
	input  index_t              readIdx3,
	input  index_t              readIdx4,
	input  data_t               rdData1,
	input  data_t               rdData2,
	input  data_t               rdData3,
	input  data_t               rdData4,
	input  logic                wbValid,    // Write-back from the ALU
	input  index_t              wbIdx,
	input  data_t               wbData,
	output data_t               srcData1,
	output data_t               srcData2,
	output data_t               srcData3,
	output data_t               pacData
);

	index_t     portIdx  [NUM_PORTS];   // Read-port indices
	data_t      portData [NUM_PORTS];   // Read-port words
	logic [1:0] srcPath  [NUM_SRCS];    // Operand view of pathSel
	index_t     selIdx   [NUM_SRCS];    // Index behind each chosen port
	data_t      selData  [NUM_SRCS];    // Word behind each chosen port
	data_t      srcData  [NUM_SRCS];    // Final operands

	////////////////////
	// Port gather
	////////////////////

	assign portIdx[0]  = readIdx1;
	assign portIdx[1]  = readIdx2;
	assign portIdx[2]  = readIdx3;
	assign portIdx[3]  = readIdx4;

	assign portData[0] = rdData1;
	assign portData[1] = rdData2;
	assign portData[2] = rdData3;
	assign portData[3] = rdData4;

	// Operand reading of the select word
	assign srcPath[0]  = pathSel.src.src1Path;
	assign srcPath[1]  = pathSel.src.src2Path;
	assign srcPath[2]  = pathSel.src.src3Path;

	////////////////////
	// Operand select
	////////////////////

	always_comb begin
		for (int i = 0; i < NUM_SRCS; i++) begin
			selIdx[i]  = portIdx[srcPath[i]];
			selData[i] = portData[srcPath[i]];

			if (!issue || !srcEn[i]) begin
				srcData[i] = '0;                        // Disabled operand
			end else if (wbValid && (wbIdx == selIdx[i])) begin
				srcData[i] = wbData;                    // Result not yet in the file
			end else begin
				srcData[i] = selData[i];
			end
		end
	end

	assign srcData1 = srcData[0];
	assign srcData2 = srcData[1];
	assign srcData3 = srcData[2];

	////////////////////
	// PAC side path
	////////////////////

	// Side-path reading of the same word, never gated or bypassed
	assign pacData = portData[pathSel.pac.pacPath];

endmodule

`default_nettype wire

//--- src/laneCore.sv
// Vector lane top level
// Register file and ALU joined through the operand network
// Write-back takes the file write port ahead of an external load

`timescale 1ns/1ns
`default_nettype none

module laneCore
	import lanePkg::*, opPkg::*;
(
	input  logic                clock,
	input  logic                rstN,
	input  logic                loadEn,     // External register load
	input  index_t              loadIdx,
	input  data_t               loadData,
	input  logic                issue,      // Instruction strobe
	input  aluOp_t              op,
	input  logic [NUM_SRCS-1:0] srcEn,
	input  pathSel_t            pathSel,
	input  index_t              readIdx1,
	input  index_t              readIdx2,
	input  index_t              readIdx3,
	input  index_t              readIdx4,
	input  index_t              dstIdx,
	output logic                wbValid,
	output index_t              wbIdx,
	output data_t               wbData,
	output logic                pacValid,
	output data_t               pacData
);

	data_t  rdData1, rdData2, rdData3, rdData4;   // Register file reads
	data_t  srcData1, srcData2, srcData3;          // ALU operands
	data_t  pacSrc;                                // Side word before the ALU stage
	logic   wrEn;
	index_t wrIdx;
	data_t  wrData;

	////////////////////
	// Write source
	////////////////////

	assign wrEn   = wbValid | loadEn;
	assign wrIdx  = wbValid ? wbIdx  : loadIdx;    // Write-back first
	assign wrData = wbValid ? wbData : loadData;

	////////////////////
	// Datapath
	////////////////////

	laneRegFile laneRegFile_i (
		.clock    (clock),
		.rstN     (rstN),
		.wrEn     (wrEn),
		.wrIdx    (wrIdx),
		.wrData   (wrData),
		.readIdx1 (readIdx1),
		.readIdx2 (readIdx2),
		.readIdx3 (readIdx3),
		.readIdx4 (readIdx4),
		.rdData1  (rdData1),
		.rdData2  (rdData2),
		.rdData3  (rdData3),
		.rdData4  (rdData4)
	);

	operandNetwork operandNetwork_i (
		.issue    (issue),
		.srcEn    (srcEn),
		.pathSel  (pathSel),
		.readIdx1 (readIdx1),
		.readIdx2 (readIdx2),
		.readIdx3 (readIdx3),
		.readIdx4 (readIdx4),
		.rdData1  (rdData1),
		.rdData2  (rdData2),
		.rdData3  (rdData3),
		.rdData4  (rdData4),
		.wbValid  (wbValid),
		.wbIdx    (wbIdx),
		.wbData   (wbData),
		.srcData1 (srcData1),
		.srcData2 (srcData2),
		.srcData3 (srcData3),
		.pacData  (pacSrc)
	);

	laneAlu laneAlu_i (
		.clock    (clock),
		.rstN     (rstN),
		.issue    (issue),
		.op       (op),
		.dstIdx   (dstIdx),
		.srcData1 (srcData1),
		.srcData2 (srcData2),
		.srcData3 (srcData3),
		.pacIn    (pacSrc),
		.wbValid  (wbValid),
		.wbIdx    (wbIdx),
		.wbData   (wbData),
		.pacValid (pacValid),
		.pacData  (pacData)
	);

endmodule

`default_nettype wire

//--- tests/laneCoreTb.sv
// Lane core testbench
// Drives loads and issues, mirrors the register file in a model and
// checks write-back and side-path words one cycle after each issue

`timescale 1ns/1ns
`default_nettype none

module laneCoreTb
	import lanePkg::*, opPkg::*;
();

	localparam int HALF_PERIOD    = 4;      // 8 ns clock
	localparam int TIMEOUT_CYCLES = 2000;   // About four times the test length

	logic                clock, rstN, loadEn, issue;
	index_t              loadIdx, readIdx1, readIdx2, readIdx3, readIdx4, dstIdx;
	data_t               loadData;
	aluOp_t              op;
	logic [NUM_SRCS-1:0] srcEn;
	pathSel_t            pathSel;
	logic                wbValid, pacValid;
	index_t              wbIdx;
	data_t               wbData, pacData;

	integer seed;
	int     cycleCount = 0;

	data_t  fileModel [NUM_REGS];   // Register file contents
	logic   pendValid;              // Result still on the write-back
	index_t pendIdx;
	data_t  pendData;

	index_t expIdxQ  [$];
	data_t  expDataQ [$];
	data_t  expPacQ  [$];
	int     headPos;                // Next entry the checker takes
	logic   chkValid;
	index_t chkIdx;
	data_t  chkData, chkPac;

	laneCore laneCore_i (
		.clock    (clock),
		.rstN     (rstN),
		.loadEn   (loadEn),
		.loadIdx  (loadIdx),
		.loadData (loadData),
		.issue    (issue),
		.op       (op),
		.srcEn    (srcEn),
		.pathSel  (pathSel),
		.readIdx1 (readIdx1),
		.readIdx2 (readIdx2),
		.readIdx3 (readIdx3),
		.readIdx4 (readIdx4),
		.dstIdx   (dstIdx),
		.wbValid  (wbValid),
		.wbIdx    (wbIdx),
		.wbData   (wbData),
		.pacValid (pacValid),
		.pacData  (pacData)
	);

	initial begin
		clock = 1'b0;
		forever #HALF_PERIOD clock = ~clock;
	end

	////////////////////
	// Reference model
	////////////////////

	function automatic data_t aluRef(input aluOp_t o, input data_t a, input data_t b,
	                                 input data_t c);
		case (o)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_MAD:  return a * b + c;          // Low 32 bits kept
			OP_AND:  return a & b;
			OP_XOR:  return a ^ b;
			OP_SEL:  return (c != '0) ? a : b;
			default: return '0;
		endcase
	endfunction

	// File value or the in-flight result on an index match
	function automatic data_t bypassRead(input index_t idx);
		return (pendValid && pendIdx == idx) ? pendData : fileModel[idx];
	endfunction

	function automatic index_t randIdx();
		return index_t'($random(seed));
	endfunction

	function automatic data_t randData();
		return data_t'($random(seed));
	endfunction

	function automatic aluOp_t randOp();
		return aluOp_t'(3'($unsigned($random(seed)) % 6));
	endfunction

	function automatic logic [2:0] randMask();
		logic [2:0] m;
		m = 3'($random(seed));
		return (m == 3'b000) ? 3'b001 : m;   // At least one dependent operand
	endfunction

	////////////////////
	// Checks
	////////////////////

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic checkData(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			abortRun($sformatf("ERROR: %s = 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic checkIdx(input string name, input index_t got, input index_t exp);
		if (got !== exp) begin
			abortRun($sformatf("ERROR: %s = 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abortRun($sformatf("ERROR: %s = 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	// Outputs seen here were registered at the previous edge
	always @(posedge clock) begin
		if (!rstN) begin
			chkValid = 1'b0;
			headPos  = 0;
		end else begin
			checkFlag("wbValid", wbValid, chkValid);
			checkFlag("pacValid", pacValid, chkValid);
			if (chkValid) begin
				checkIdx("wbIdx", wbIdx, chkIdx);
				checkData("wbData", wbData, chkData);
				checkData("pacData", pacData, chkPac);
			end
			chkValid = issue;
			if (issue) begin
				chkIdx  = expIdxQ[headPos];
				chkData = expDataQ[headPos];
				chkPac  = expPacQ[headPos];
				headPos = headPos + 1;
			end
		end
	end

	always @(posedge clock) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			abortRun($sformatf("Timeout: tests still running after %0d cycles", cycleCount));
		end
	end

	////////////////////
	// Stimulus
	////////////////////

	task automatic commitPending();
		if (pendValid) begin
			fileModel[pendIdx] = pendData;
		end
		pendValid = 1'b0;
	endtask

	task automatic idleCycle();
		@(negedge clock);
		issue  = 1'b0;
		loadEn = 1'b0;
		commitPending();
	endtask

	task automatic loadReg(input index_t idx, input data_t data);
		if (pendValid) begin
			idleCycle();                      // Keep load off a write-back cycle
		end
		@(negedge clock);
		issue          = 1'b0;
		loadEn         = 1'b1;
		loadIdx        = idx;
		loadData       = data;
		fileModel[idx] = data;
	endtask

	task automatic issueOp(input aluOp_t o, input logic [2:0] en, input pathSel_t sel,
	                       input index_t i1, i2, i3, i4, input index_t dst);
		index_t     idxs [4];
		logic [1:0] paths [3];
		data_t      opnd [3];
		data_t      expPac;
		@(negedge clock);
		idxs     = '{i1, i2, i3, i4};
		paths[0] = sel.src.src1Path;
		paths[1] = sel.src.src2Path;
		paths[2] = sel.src.src3Path;
		for (int s = 0; s < 3; s++) begin
			opnd[s] = en[s] ? bypassRead(idxs[paths[s]]) : '0;
		end
		expPac = fileModel[idxs[sel.pac.pacPath]];   // No bypass on the side path
		issue    = 1'b1;
		loadEn   = 1'b0;
		op       = o;
		srcEn    = en;
		pathSel  = sel;
		readIdx1 = i1;
		readIdx2 = i2;
		readIdx3 = i3;
		readIdx4 = i4;
		dstIdx   = dst;
		expIdxQ.push_back(dst);
		expDataQ.push_back(aluRef(o, opnd[0], opnd[1], opnd[2]));
		expPacQ.push_back(expPac);
		commitPending();
		pendValid = 1'b1;
		pendIdx   = dst;
		pendData  = expDataQ[expDataQ.size() - 1];
	endtask

	// Random ports with the masked operands pointed at depIdx
	task automatic issueRandom(input aluOp_t o, input logic [2:0] en, input index_t dst,
	                           input logic [2:0] depMask, input index_t depIdx);
		pathSel_t sel;
		index_t   idxs [4];
		logic [1:0] paths [3];
		sel      = pathSel_t'(6'($random(seed)));
		paths[0] = sel.src.src1Path;
		paths[1] = sel.src.src2Path;
		paths[2] = sel.src.src3Path;
		for (int p = 0; p < 4; p++) begin
			idxs[p] = randIdx();
		end
		for (int s = 0; s < 3; s++) begin
			if (depMask[s]) begin
				idxs[paths[s]] = depIdx;
			end
		end
		issueOp(o, en, sel, idxs[0], idxs[1], idxs[2], idxs[3], dst);
	endtask

	initial begin
		int     pick;
		index_t dst;
		index_t lastDst;
		seed      = 32'ha28b_db20;
		rstN      = 1'b0;
		loadEn    = 1'b0;
		loadIdx   = '0;
		loadData  = '0;
		issue     = 1'b0;
		op        = OP_ADD;
		srcEn     = '0;
		pathSel   = '0;
		readIdx1  = '0;
		readIdx2  = '0;
		readIdx3  = '0;
		readIdx4  = '0;
		dstIdx    = '0;
		pendValid = 1'b0;
		pendIdx   = '0;
		pendData  = '0;
		lastDst   = '0;
		for (int r = 0; r < NUM_REGS; r++) begin
			fileModel[r] = '0;
		end
		repeat (2) @(posedge clock);
		@(negedge clock);
		rstN = 1'b1;

		// All sources off gives a zero result
		idleCycle();
		issueOp(OP_ADD, 3'b000, pathSel_t'(6'h1b), 5'd3, 5'd4, 5'd5, 5'd6, 5'd9);
		idleCycle();

		for (int r = 0; r < NUM_REGS; r++) begin
			loadReg(index_t'(r), randData());
		end
		for (int o = 0; o < 6; o++) begin
			repeat (4) begin
				issueRandom(aluOp_t'(3'(o)), 3'b111, randIdx(), 3'b000, '0);
				idleCycle();
			end
		end

		// Each issue in the chain reads the previous destination
		repeat (24) begin
			dst = randIdx();
			issueRandom(randOp(), 3'b111, dst, randMask(), lastDst);
			lastDst = dst;
		end

		// Side path with any mix of enables
		repeat (12) begin
			issueRandom(randOp(), 3'($random(seed)), randIdx(), 3'b000, '0);
		end

		repeat (300) begin
			pick = $unsigned($random(seed)) % 4;
			case (pick)
				0: loadReg(randIdx(), randData());
				1: idleCycle();
				default: begin
					dst = randIdx();
					issueRandom(randOp(), 3'($random(seed)), dst, randMask(), lastDst);
					lastDst = dst;
				end
			endcase
		end

		// Read every register back through operand 1
		for (int r = 0; r < NUM_REGS; r++) begin
			issueOp(OP_ADD, 3'b001, '0, index_t'(r), randIdx(), randIdx(), randIdx(),
			        index_t'(r));
		end

		repeat (3) idleCycle();
		$display("Checked %0d results", headPos);
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
src/lanePkg.sv
src/opPkg.sv
src/laneRegFile.sv
src/laneAlu.sv
src/operandNetwork.sv
src/laneCore.sv
tests/laneCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the lane core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timescale 1ns/1ns -f sim.f --top-module laneCoreTb -o laneCoreSim

./obj_dir/laneCoreSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
	exit 1
fi
grep -q "Verification passed" sim.log
